/* all.f */
rtl/cdb_pkg.sv
rtl/fu_result_port.sv
rtl/cdb_arbiter.sv
rtl/preg_file.sv
rtl/cdb_top.sv
tests/cdb_properties.sv
tests/cdb_checker.sv
tests/tb_cdb_top.sv

/* rtl/cdb_arbiter.sv */
module cdb_arbiter (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        flush_i,
    input  logic                [cdb_pkg::FU_COUNT-1:0]  head_valid_i,
    input  cdb_pkg::fu_result_t [cdb_pkg::FU_COUNT-1:0]  heads_i,
    output logic                [cdb_pkg::FU_COUNT-1:0]  grant_o,
    output cdb_pkg::cdb_lane_t  [cdb_pkg::CDB_COUNT-1:0] cdb_o
);

    cdb_pkg::fu_sel_t ptr_q;   // highest priority port

    logic             [cdb_pkg::FU_COUNT-1:0]  eligible;
    cdb_pkg::fu_sel_t [cdb_pkg::CDB_COUNT-1:0] sel;
    logic             [cdb_pkg::CDB_COUNT-1:0] ok;
    cdb_pkg::fu_sel_t                          last;

    logic                [cdb_pkg::CDB_COUNT-1:0] lane_valid_q;
    cdb_pkg::fu_result_t [cdb_pkg::CDB_COUNT-1:0] lane_res_q;

    assign eligible = head_valid_i & {cdb_pkg::FU_COUNT{~flush_i}};  // no grants during flush

    // walk the ports from the pointer, fill lanes in order
    always_comb begin : pick
        cdb_pkg::fu_sel_t idx;
        int               n;
        sel  = '0;
        ok   = '0;
        last = ptr_q;
        n    = 0;
        for (int i = 0; i < cdb_pkg::FU_COUNT; i++) begin
            idx = cdb_pkg::fu_sel_t'(ptr_q + i);
            if (eligible[idx] && n < cdb_pkg::CDB_COUNT) begin
                sel[n] = idx;
                ok[n]  = 1'b1;
                last   = idx;
                n      = n + 1;
            end
        end
    end

    always_comb begin
        grant_o = '0;
        for (int k = 0; k < cdb_pkg::FU_COUNT; k++) begin
            for (int l = 0; l < cdb_pkg::CDB_COUNT; l++) begin
                if (ok[l] && sel[l] == cdb_pkg::fu_sel_t'(k)) grant_o[k] = 1'b1;
            end
        end
    end

    // ok is all zero under flush, so the lanes clear on the next edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q        <= '0;
            lane_valid_q <= '0;
        end else begin
            lane_valid_q <= ok;
            if (|ok) ptr_q <= last + 1'b1;   // port after the last one granted
        end
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < cdb_pkg::CDB_COUNT; l++) begin
            if (ok[l]) lane_res_q[l] <= heads_i[sel[l]];
        end
    end

    always_comb begin
        for (int l = 0; l < cdb_pkg::CDB_COUNT; l++) begin
            cdb_o[l].valid = lane_valid_q[l];
            cdb_o[l].preg  = lane_res_q[l].preg;
            cdb_o[l].data  = lane_res_q[l].data;
            cdb_o[l].w_reg = lane_res_q[l].w_reg;
        end
    end

endmodule

/* rtl/cdb_pkg.sv */
package cdb_pkg;

    localparam int FU_COUNT    = 4;   // functional-unit result ports
    localparam int CDB_COUNT   = 2;   // broadcast lanes
    localparam int QUEUE_DEPTH = 2;   // entries per result queue
    localparam int PREG_COUNT  = 64;

    // queue pointer and occupancy widths
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [31:0]                   word_t;
    typedef logic [$clog2(PREG_COUNT)-1:0] preg_id_t;
    typedef logic [$clog2(FU_COUNT)-1:0]   fu_sel_t;
    typedef logic [QPTR_W-1:0]             qptr_t;
    typedef logic [QCNT_W-1:0]             qcnt_t;

    // one finished result from a functional unit
    typedef struct packed {
        preg_id_t preg;
        word_t    data;
        logic     w_reg;   // result writes a register
    } fu_result_t;

    // one CDB broadcast lane
    typedef struct packed {
        logic     valid;
        preg_id_t preg;
        word_t    data;
        logic     w_reg;
    } cdb_lane_t;

    // four-phase receiver
    typedef enum logic {
        WAIT_REQ,
        HOLD_ACK
    } port_state_t;

endpackage

/* rtl/cdb_top.sv */
module cdb_top (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        flush_i,
    input  logic                [cdb_pkg::FU_COUNT-1:0]  fu_req_i,
    input  cdb_pkg::fu_result_t [cdb_pkg::FU_COUNT-1:0]  fu_result_i,
    output logic                [cdb_pkg::FU_COUNT-1:0]  fu_ack_o,
    output cdb_pkg::cdb_lane_t  [cdb_pkg::CDB_COUNT-1:0] cdb_o,
    input  cdb_pkg::preg_id_t                           rd_preg_i,
    output cdb_pkg::word_t                              rd_data_o
);

    logic                [cdb_pkg::FU_COUNT-1:0] head_valid;
    cdb_pkg::fu_result_t [cdb_pkg::FU_COUNT-1:0] heads;
    logic                [cdb_pkg::FU_COUNT-1:0] grant;

    // one receiver and queue per functional unit
    for (genvar k = 0; k < cdb_pkg::FU_COUNT; k++) begin : g_port
        fu_result_port u_port (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .req_i       (fu_req_i[k]),
            .result_i    (fu_result_i[k]),
            .ack_o       (fu_ack_o[k]),
            .grant_i     (grant[k]),
            .head_valid_o(head_valid[k]),
            .head_o      (heads[k])
        );
    end

    cdb_arbiter u_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .head_valid_i(head_valid),
        .heads_i     (heads),
        .grant_o     (grant),
        .cdb_o       (cdb_o)
    );

    // the register file is the only consumer of the lanes inside
    preg_file u_preg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .cdb_i    (cdb_o),
        .rd_preg_i(rd_preg_i),
        .rd_data_o(rd_data_o)
    );

endmodule

/* rtl/fu_result_port.sv */
module fu_result_port (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                req_i,
    input  cdb_pkg::fu_result_t result_i,
    output logic                ack_o,
    input  logic                grant_i,
    output logic                head_valid_o,
    output cdb_pkg::fu_result_t head_o
);

    cdb_pkg::port_state_t state_q;
    cdb_pkg::port_state_t state_d;

    cdb_pkg::fu_result_t mem_q [cdb_pkg::QUEUE_DEPTH];
    cdb_pkg::qptr_t      wr_ptr_q;
    cdb_pkg::qptr_t      rd_ptr_q;
    cdb_pkg::qcnt_t      count_q;

    logic full;
    logic push;
    logic pop;

    function automatic cdb_pkg::qptr_t next_ptr(cdb_pkg::qptr_t p);
        return (p == cdb_pkg::qptr_t'(cdb_pkg::QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count_q == cdb_pkg::qcnt_t'(cdb_pkg::QUEUE_DEPTH));
    assign push = (state_q == cdb_pkg::WAIT_REQ) && req_i && !full; // full queue holds ack back
    assign pop  = grant_i && head_valid_o;

    // receiver FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            cdb_pkg::WAIT_REQ: if (push) state_d = cdb_pkg::HOLD_ACK;
            cdb_pkg::HOLD_ACK: if (!req_i) state_d = cdb_pkg::WAIT_REQ;   // req dropped
            default:           state_d = cdb_pkg::WAIT_REQ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= cdb_pkg::WAIT_REQ;
        end else begin
            state_q <= state_d;   // flush leaves the handshake alone
        end
    end

    assign ack_o = (state_q == cdb_pkg::HOLD_ACK);

    // queue control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything queued, keep a result taken on this edge
            wr_ptr_q <= cdb_pkg::qptr_t'(push);
            rd_ptr_q <= '0;
            count_q  <= cdb_pkg::qcnt_t'(push);
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q <= count_q + cdb_pkg::qcnt_t'(push) - cdb_pkg::qcnt_t'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[flush_i ? '0 : wr_ptr_q] <= result_i;
        end
    end

    assign head_valid_o = (count_q != '0);
    assign head_o       = mem_q[rd_ptr_q];

endmodule

/* rtl/preg_file.sv */
module preg_file (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  cdb_pkg::cdb_lane_t [cdb_pkg::CDB_COUNT-1:0] cdb_i,
    input  cdb_pkg::preg_id_t                          rd_preg_i,
    output cdb_pkg::word_t                             rd_data_o
);

    cdb_pkg::word_t regs_q [cdb_pkg::PREG_COUNT];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < cdb_pkg::PREG_COUNT; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // highest lane first so lane 0 lands last and wins a collision
            for (int l = cdb_pkg::CDB_COUNT - 1; l >= 0; l--) begin
                if (cdb_i[l].valid && cdb_i[l].w_reg) begin
                    regs_q[cdb_i[l].preg] <= cdb_i[l].data;
                end
            end
        end
    end

    assign rd_data_o = regs_q[rd_preg_i];   // combinational read

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module tb_cdb_top -o sim_cdb
./obj_dir/sim_cdb > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
echo "simulation did not pass"
exit 1

/* tests/cdb_checker.sv */
module cdb_checker (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        flush_i,
    input  logic                [cdb_pkg::FU_COUNT-1:0]  fu_req_i,
    input  cdb_pkg::fu_result_t [cdb_pkg::FU_COUNT-1:0]  fu_result_i,
    input  logic                [cdb_pkg::FU_COUNT-1:0]  fu_ack_i,
    input  cdb_pkg::cdb_lane_t  [cdb_pkg::CDB_COUNT-1:0] cdb_i,
    input  logic                                        rd_chk_i,
    input  cdb_pkg::preg_id_t                           rd_preg_i,
    input  cdb_pkg::word_t                              rd_exp_i,
    input  cdb_pkg::word_t                              rd_data_i,
    output int                                          lane_errors_o,
    output int                                          read_errors_o,
    output int                                          pending_o
);

    cdb_pkg::fu_result_t pend [cdb_pkg::FU_COUNT][$];   // accepted, not yet broadcast
    logic [cdb_pkg::FU_COUNT-1:0] ack_prev;

    initial begin
        lane_errors_o = 0;
        read_errors_o = 0;
        pending_o     = 0;
        ack_prev      = '0;
    end

    always @(posedge clk_i) begin
        int found_p;
        int found_j;
        int sum;
        if (rst_n_i) begin
            // a rising ack marks an accepted result
            for (int p = 0; p < cdb_pkg::FU_COUNT; p++) begin
                if (fu_ack_i[p] && !ack_prev[p] && fu_req_i[p]) pend[p].push_back(fu_result_i[p]);
            end
            for (int l = 0; l < cdb_pkg::CDB_COUNT; l++) begin
                if (cdb_i[l].valid) begin
                    found_p = -1;
                    found_j = -1;
                    for (int p = 0; p < cdb_pkg::FU_COUNT; p++) begin
                        for (int j = 0; j < pend[p].size(); j++) begin
                            if (found_p < 0 && pend[p][j].preg == cdb_i[l].preg) begin
                                found_p = p;
                                found_j = j;
                            end
                        end
                    end
                    if (found_p < 0) begin
                        $display("FAIL %0t: lane %0d carries unknown preg %0d",
                                 $time, l, cdb_i[l].preg);
                        lane_errors_o++;
                    end else begin
                        if (found_j != 0) begin
                            $display("FAIL %0t: preg %0d left port %0d out of order",
                                     $time, cdb_i[l].preg, found_p);
                            lane_errors_o++;
                        end
                        if (pend[found_p][found_j].data != cdb_i[l].data ||
                            pend[found_p][found_j].w_reg != cdb_i[l].w_reg) begin
                            $display("FAIL %0t: preg %0d lane %0d got %h/%0b, want %h/%0b",
                                     $time, cdb_i[l].preg, l, cdb_i[l].data, cdb_i[l].w_reg,
                                     pend[found_p][found_j].data, pend[found_p][found_j].w_reg);
                            lane_errors_o++;
                        end
                        pend[found_p].delete(found_j);
                    end
                end
            end
            // whatever is still queued at a flush is gone
            if (flush_i) begin
                for (int p = 0; p < cdb_pkg::FU_COUNT; p++) pend[p].delete();
            end
            if (rd_chk_i && rd_data_i != rd_exp_i) begin
                $display("FAIL %0t: preg %0d reads %h, want %h",
                         $time, rd_preg_i, rd_data_i, rd_exp_i);
                read_errors_o++;
            end
        end
        sum = 0;
        for (int p = 0; p < cdb_pkg::FU_COUNT; p++) sum += pend[p].size();
        pending_o = sum;
        ack_prev  = rst_n_i ? fu_ack_i : '0;
    end

endmodule

/* tests/cdb_properties.sv */
module cdb_properties (
    input logic                                       clk_i,
    input logic                                       rst_n_i,
    input logic                                       flush_i,
    input logic               [cdb_pkg::FU_COUNT-1:0]  fu_req_i,
    input logic               [cdb_pkg::FU_COUNT-1:0]  fu_ack_o,
    input logic               [cdb_pkg::FU_COUNT-1:0]  head_valid,
    input logic               [cdb_pkg::FU_COUNT-1:0]  grant,
    input cdb_pkg::cdb_lane_t [cdb_pkg::CDB_COUNT-1:0] cdb_o
);

    int fail_count = 0;   // failed assertions so far

    // no ack and no lane traffic on the first clock out of reset
    a_reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (fu_ack_o == '0) && !cdb_o[0].valid && !cdb_o[1].valid)
        else begin
            $error("ack or lane valid high right after reset");
            fail_count++;
        end

    for (genvar k = 0; k < cdb_pkg::FU_COUNT; k++) begin : g_port
        a_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $rose(fu_ack_o[k]) |-> $past(fu_req_i[k]))
            else begin
                $error("port %0d raised ack without req", k);
                fail_count++;
            end

        a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $fell(fu_ack_o[k]) |-> !$past(fu_req_i[k]))
            else begin
                $error("port %0d dropped ack while req was high", k);
                fail_count++;
            end

        // two lanes and four ports allow one waiting cycle at most
        a_no_starve: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            head_valid[k] && !grant[k] && !flush_i |=> grant[k] || flush_i)
            else begin
                $error("port %0d head left ungranted", k);
                fail_count++;
            end
    end

endmodule

bind cdb_top cdb_properties u_props (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .fu_req_i  (fu_req_i),
    .fu_ack_o  (fu_ack_o),
    .head_valid(head_valid),
    .grant     (grant),
    .cdb_o     (cdb_o)
);

/* tests/tb_cdb_top.sv */
module tb_cdb_top;

    localparam int ROWS       = 24;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        cdb_pkg::fu_sel_t  port;
        cdb_pkg::preg_id_t preg;
        cdb_pkg::word_t    data;
        logic              w_reg;
        logic              flush_before;
        logic [1:0]        gap;        // idle cycles before req
        cdb_pkg::word_t    expect_reg; // register contents after drain
    } row_t;

    logic                                        clk_i;
    logic                                        rst_n_i;
    logic                                        flush_i;
    logic                [cdb_pkg::FU_COUNT-1:0]  fu_req;
    cdb_pkg::fu_result_t [cdb_pkg::FU_COUNT-1:0]  fu_result;
    logic                [cdb_pkg::FU_COUNT-1:0]  fu_ack;
    cdb_pkg::cdb_lane_t  [cdb_pkg::CDB_COUNT-1:0] cdb;
    cdb_pkg::preg_id_t                           rd_preg;
    cdb_pkg::word_t                              rd_data;
    logic                                        rd_chk;
    cdb_pkg::word_t                              rd_exp;
    int lane_errors;
    int read_errors;
    int pending;
    int timeouts;
    int assert_errors;
    int total;

    row_t           tbl [ROWS];
    cdb_pkg::word_t burst_data [cdb_pkg::FU_COUNT];
    logic [31:0]    lfsr;

    cdb_top uut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .fu_req_i   (fu_req),
        .fu_result_i(fu_result),
        .fu_ack_o   (fu_ack),
        .cdb_o      (cdb),
        .rd_preg_i  (rd_preg),
        .rd_data_o  (rd_data)
    );

    cdb_checker chk (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .fu_req_i(fu_req), .fu_result_i(fu_result), .fu_ack_i(fu_ack), .cdb_i(cdb),
        .rd_chk_i(rd_chk), .rd_preg_i(rd_preg), .rd_exp_i(rd_exp), .rd_data_i(rd_data),
        .lane_errors_o(lane_errors), .read_errors_o(read_errors), .pending_o(pending)
    );

    always #5 clk_i = ~clk_i;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic build_table();
        logic [31:0] v;
        for (int i = 0; i < cdb_pkg::FU_COUNT; i++) begin
            burst_data[i] = draw_bits(32);
        end
        for (int i = 0; i < ROWS; i++) begin
            tbl[i].port = cdb_pkg::fu_sel_t'(i % cdb_pkg::FU_COUNT);
            tbl[i].preg = cdb_pkg::preg_id_t'(i + 1);   // unique per row
            tbl[i].data = draw_bits(32);
            v = draw_bits(1);
            tbl[i].w_reg = v[0];
            v = draw_bits(2);
            tbl[i].gap          = v[1:0];
            tbl[i].flush_before = (i == 8) || (i == 16);
            tbl[i].expect_reg   = tbl[i].w_reg ? tbl[i].data : '0;
        end
    endtask

    // second half of the four-phase handshake
    task automatic finish_handshake(input int p);
        int t;
        t = 0;
        @(posedge clk_i);
        while (!fu_ack[p] && t < WAIT_LIMIT) begin
            @(posedge clk_i);
            t++;
        end
        if (!fu_ack[p]) begin
            $display("timeout: port %0d never raised ack", p);
            timeouts++;
        end else begin
            fu_req[p] <= 1'b0;
            t = 0;
            @(posedge clk_i);
            while (fu_ack[p] && t < WAIT_LIMIT) begin
                @(posedge clk_i);
                t++;
            end
            if (fu_ack[p]) begin
                $display("timeout: port %0d kept ack high after req fell", p);
                timeouts++;
            end
        end
    endtask

    task automatic send(input int p, input cdb_pkg::fu_result_t r);
        @(posedge clk_i);
        fu_req[p]    <= 1'b1;
        fu_result[p] <= r;
        finish_handshake(p);
    endtask

    task automatic run_port(input int p, input int lo, input int hi);
        cdb_pkg::fu_result_t r;
        for (int i = lo; i < hi; i++) begin
            if (int'(tbl[i].port) == p) begin
                repeat (tbl[i].gap) @(posedge clk_i);
                r.preg  = tbl[i].preg;
                r.data  = tbl[i].data;
                r.w_reg = tbl[i].w_reg;
                send(p, r);
            end
        end
    endtask

    task automatic run_rows(input int lo, input int hi);
        if (tbl[lo].flush_before) begin
            @(posedge clk_i);
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
        end
        fork
            run_port(0, lo, hi);
            run_port(1, lo, hi);
            run_port(2, lo, hi);
            run_port(3, lo, hi);
        join
    endtask

    // all four ports at once right after reset; pointer is 0, so ports 0 and 1
    // win the first cycle and the flush drops ports 2 and 3
    task automatic flush_burst();
        @(posedge clk_i);
        for (int p = 0; p < cdb_pkg::FU_COUNT; p++) begin
            fu_req[p]          <= 1'b1;
            fu_result[p].preg  <= cdb_pkg::preg_id_t'(60 + p);
            fu_result[p].data  <= burst_data[p];
            fu_result[p].w_reg <= 1'b1;
        end
        fork
            finish_handshake(0);
            finish_handshake(1);
            finish_handshake(2);
            finish_handshake(3);
            begin
                repeat (2) @(posedge clk_i);
                flush_i <= 1'b1;
                @(posedge clk_i);
                flush_i <= 1'b0;
            end
        join
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (pending != 0 && t < WAIT_LIMIT) begin
            @(posedge clk_i);
            t++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results never reached a lane", pending);
            timeouts++;
        end
        repeat (3) @(posedge clk_i);   // last lane write lands
    endtask

    task automatic check_reg(input int preg, input cdb_pkg::word_t value);
        @(posedge clk_i);
        rd_preg <= cdb_pkg::preg_id_t'(preg);
        rd_exp  <= value;
        rd_chk  <= 1'b1;
    endtask

    initial begin
        int start;
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        flush_i   = 1'b0;
        fu_req    = '0;
        fu_result = '0;
        rd_preg   = '0;
        rd_exp    = '0;
        rd_chk    = 1'b0;
        timeouts  = 0;
        lfsr      = 32'h22f1df17;
        build_table();
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        flush_burst();
        wait_drained();

        start = 0;
        for (int i = 1; i <= ROWS; i++) begin
            if (i == ROWS || tbl[i].flush_before) begin
                run_rows(start, i);
                start = i;
            end
        end
        wait_drained();

        check_reg(60, burst_data[0]);
        check_reg(61, burst_data[1]);
        check_reg(62, '0);
        check_reg(63, '0);
        for (int i = 0; i < ROWS; i++) check_reg(int'(tbl[i].preg), tbl[i].expect_reg);
        @(posedge clk_i);
        rd_chk <= 1'b0;
        @(posedge clk_i);

        assert_errors = uut.u_props.fail_count;
        total = lane_errors + read_errors + timeouts + assert_errors;
        $display("errors: lane %0d, readback %0d, assertions %0d, timeouts %0d",
                 lane_errors, read_errors, assert_errors, timeouts);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
